/* compile.f */
+incdir+.
mipsPkg.sv
fetchUnit.sv
instrDecoder.sv
regFile.sv
executeUnit.sv
memAccess.sv
cpuTop.sv
cpuTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = cpuTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* cpuRefModel.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////
function automatic logic [31:0] encR(input functE fn, input int rd, input int rs, input int rt);
    return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic logic [31:0] encI(input opcodeE op, input int rt, input int rs,
                                    input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic logic [31:0] encJ(input logic [25:0] index);
    return {OP_J, index};
endfunction

////////////////////////////////////////
// Instruction-set model
////////////////////////////////////////
// Runs the program for a number of instructions and collects
// the PC of each one and every data write it makes
function automatic void runRef(input logic [31:0] prog[256], input logic [31:0] memInit[256],
                               input logic [31:0] startPc, input int steps,
                               output dmemReqT wrs[$], output logic [31:0] pcs[$]);
    logic [31:0] r[32];
    logic [31:0] m[256];
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] instr;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] addr;
    logic [7:0]  b;
    int          rs;
    int          rt;
    int          rd;
    dmemReqT     w;
    wrs = {};
    pcs = {};
    for (int i = 0; i < 32; i++) r[i] = '0;
    m  = memInit;
    pc = startPc;
    for (int k = 0; k < steps; k++) begin
        pcs.push_back(pc);
        instr  = prog[pc[9:2]];
        rs     = instr[25:21];
        rt     = instr[20:16];
        rd     = instr[15:11];
        sext   = {{16{instr[15]}}, instr[15:0]};
        zext   = {16'h0000, instr[15:0]};
        addr   = r[rs] + sext;
        nextPc = pc + 32'd4;
        case (instr[31:26])
            OP_RTYPE: begin
                case (instr[5:0])
                    FN_ADD: r[rd] = r[rs] + r[rt];
                    FN_SUB: r[rd] = r[rs] - r[rt];
                    FN_AND: r[rd] = r[rs] & r[rt];
                    FN_OR:  r[rd] = r[rs] | r[rt];
                    FN_SLT: r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            OP_ADDI: r[rt] = r[rs] + sext;
            OP_SLTI: r[rt] = ($signed(r[rs]) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_ANDI: r[rt] = r[rs] & zext;
            OP_ORI:  r[rt] = r[rs] | zext;
            OP_LUI:  r[rt] = {instr[15:0], 16'h0000};
            OP_LW:   r[rt] = m[addr[9:2]];
            OP_LB: begin
                b     = 8'(m[addr[9:2]] >> (8 * addr[1:0]));
                r[rt] = {{24{b[7]}}, b};
            end
            OP_SW, OP_SB: begin
                w.addr = {addr[31:2], 2'b00};
                w.wrEn = 1'b1;
                if (instr[31:26] == OP_SW) begin
                    w.wrData = r[rt];
                    w.byteEn = 4'b1111;
                end else begin
                    w.wrData = {4{r[rt][7:0]}};
                    w.byteEn = 4'b0001 << addr[1:0];
                end
                for (int l = 0; l < 4; l++) begin
                    if (w.byteEn[l]) m[addr[9:2]][8*l +: 8] = w.wrData[8*l +: 8];
                end
                wrs.push_back(w);
            end
            OP_BEQ: if (r[rs] == r[rt]) nextPc = pc + 32'd4 + {sext[29:0], 2'b00};
            OP_BNE: if (r[rs] != r[rt]) nextPc = pc + 32'd4 + {sext[29:0], 2'b00};
            // Region bits come from the address after the jump
            OP_J:   nextPc = {nextPc[31:28], instr[25:0], 2'b00};
            default: ;
        endcase
        // $zero never holds a value
        r[0] = '0;
        pc   = nextPc;
    end
endfunction

`endif

/* cpuTb.sv */
module cpuTb
    import mipsPkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    `include "cpuRefModel.svh"

    localparam logic [31:0] RESET_PC     = 32'h0000_0000;
    localparam int          RESET_CYCLES = 16;

    logic        i_clk;
    logic        i_rstN;
    logic [31:0] i_imemData;
    logic [31:0] i_dmemRdData;
    logic [31:0] o_imemAddr;
    dmemReqT     o_dmemReq;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] memInit [256];
    int          progLen;

    dmemReqT     expWr[$];
    logic [31:0] expPc[$];
    bit          monActive;
    int          cycleIdx;
    int          wrIdx;
    int          errCount;
    int          testCount;
    int          passCount;
    int          cycleCount;
    int          cycleLimit;

    cpuTop #(
        .RESET_PC     (RESET_PC    )
    ) u_cpuTop (
        .i_clk        (i_clk       ),
        .i_rstN       (i_rstN      ),
        .i_imemData   (i_imemData  ),
        .i_dmemRdData (i_dmemRdData),
        .o_imemAddr   (o_imemAddr  ),
        .o_dmemReq    (o_dmemReq   )
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    ////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////
    always_comb begin
        i_imemData   = imem[o_imemAddr[9:2]];
        i_dmemRdData = dmem[o_dmemReq.addr[9:2]];
    end

    always @(posedge i_clk) begin
        if (o_dmemReq.wrEn) begin
            for (int l = 0; l < 4; l++) begin
                if (o_dmemReq.byteEn[l]) begin
                    dmem[o_dmemReq.addr[9:2]][8*l +: 8] <= o_dmemReq.wrData[8*l +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic compareReq(input dmemReqT got, input dmemReqT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: write addr %h data %h en %b, expected addr %h data %h en %b",
                     $time, got.addr, got.wrData, got.byteEn, exp.addr, exp.wrData, exp.byteEn);
            errCount++;
        end
    endtask

    task automatic comparePc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: PC %h, expected %h", $time, got, exp);
            errCount++;
        end
    endtask

    // Monitor samples the values that stand before each rising edge
    always @(posedge i_clk) begin
        cycleCount++;
        if (!i_rstN) begin
            // Core state is defined once reset has been held over one edge
            if (cycleCount > 1) begin
                comparePc(o_imemAddr, RESET_PC);
                if (o_dmemReq.wrEn) begin
                    $display("Memory write seen while the core is in reset at %0t", $time);
                    errCount++;
                end
            end
        end else if (monActive) begin
            if (cycleIdx < 0) begin
                // Valid still low in this cycle
                comparePc(o_imemAddr, RESET_PC);
                if (o_dmemReq.wrEn) begin
                    $display("Memory write seen in the first cycle after reset at %0t", $time);
                    errCount++;
                end
            end else begin
                if (cycleIdx < expPc.size()) comparePc(o_imemAddr, expPc[cycleIdx]);
                if (o_dmemReq.wrEn) begin
                    if (wrIdx < expWr.size()) begin
                        compareReq(o_dmemReq, expWr[wrIdx]);
                    end else begin
                        $display("Unexpected extra memory write at %0t to %h", $time,
                                 o_dmemReq.addr);
                        errCount++;
                    end
                    wrIdx++;
                end
            end
            cycleIdx++;
        end
    end

    always @(posedge i_clk) begin
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Program building and running
    ////////////////////////////////////////
    task automatic clearProgram();
        progLen = 0;
        for (int i = 0; i < 256; i++) imem[i] = 32'h0000_0000;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic emitJumpSelf();
        logic [31:0] here;
        here = RESET_PC + 32'(progLen * 4);
        emit(encJ(here[27:2]));
    endtask

    task automatic runProgram(input string name, input int steps);
        int errBefore;
        errBefore = errCount;
        cycleLimit += steps + RESET_CYCLES + 4;
        @(negedge i_clk);
        i_rstN = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        // Fill pattern varies with every address bit
        for (int i = 0; i < 256; i++) begin
            memInit[i] = {8'hc3 ^ 8'(i), 8'(i), ~8'(i), 8'(i) + 8'h3c};
            dmem[i]    = memInit[i];
        end
        runRef(imem, memInit, RESET_PC, steps, expWr, expPc);
        cycleIdx  = -1;
        wrIdx     = 0;
        monActive = 1'b1;
        i_rstN    = 1'b1;
        while (cycleIdx < steps) @(negedge i_clk);
        monActive = 1'b0;
        if (wrIdx < expWr.size()) begin
            $display("Missing memory writes: saw %0d of %0d", wrIdx, expWr.size());
            errCount++;
        end
        testCount++;
        if (errCount == errBefore) begin
            passCount++;
            $display("Test %s passed, %0d writes", name, expWr.size());
        end else begin
            $display("Test %s failed, %0d errors", name, errCount - errBefore);
        end
    endtask

    task automatic buildRandom();
        int kind;
        int rd;
        int rs;
        int rt;
        logic [15:0] imm;
        logic [15:0] off;
        logic [15:0] boff;
        clearProgram();
        // r1 is the data base and is never overwritten
        emit(encI(OP_ADDI, 1, 0, 16'h0100));
        for (int n = 0; n < 100; n++) begin
            kind = $urandom_range(13, 0);
            rd   = $urandom_range(31, 2);
            rs   = $urandom_range(31, 0);
            rt   = $urandom_range(31, 0);
            imm  = 16'($urandom);
            off  = 16'($urandom_range(191, 0) * 4);
            boff = 16'($urandom_range(767, 0));
            case (kind)
                0:  emit(encR(FN_ADD, rd, rs, rt));
                1:  emit(encR(FN_SUB, rd, rs, rt));
                2:  emit(encR(FN_AND, rd, rs, rt));
                3:  emit(encR(FN_OR, rd, rs, rt));
                4:  emit(encR(FN_SLT, rd, rs, rt));
                5:  emit(encI(OP_ADDI, rd, rs, imm));
                6:  emit(encI(OP_ANDI, rd, rs, imm));
                7:  emit(encI(OP_ORI, rd, rs, imm));
                8:  emit(encI(OP_SLTI, rd, rs, imm));
                9:  emit(encI(OP_LUI, rd, 0, imm));
                10: emit(encI(OP_LW, rd, 1, off));
                11: emit(encI(OP_LB, rd, 1, boff));
                12: emit(encI(OP_SW, rt, 1, off));
                default: emit(encI(OP_SB, rt, 1, boff));
            endcase
            if (kind < 12) emit(encI(OP_SW, rd, 1, off));
        end
        emitJumpSelf();
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    initial begin
        i_rstN     = 1'b0;
        monActive  = 1'b0;
        cycleIdx   = 0;
        wrIdx      = 0;
        errCount   = 0;
        testCount  = 0;
        passCount  = 0;
        cycleCount = 0;
        cycleLimit = RESET_CYCLES + 64;
        void'($urandom(32'h0f08_41aa));
        for (int i = 0; i < 256; i++) dmem[i] = '0;
        clearProgram();

        // Straight-line code after reset
        emit(encI(OP_ADDI, 1, 0, 16'h0011));
        emit(encI(OP_ADDI, 2, 1, 16'h0022));
        emit(encI(OP_SW, 2, 0, 16'h0010));
        emit(encI(OP_ADDI, 3, 2, 16'hfff0));
        emit(encI(OP_SW, 3, 0, 16'h0014));
        emitJumpSelf();
        runProgram("reset", progLen + 6);

        // Arithmetic with each result stored
        clearProgram();
        emit(encI(OP_ADDI, 1, 0, 16'h1234));
        emit(encI(OP_ADDI, 2, 0, 16'hfffb));
        emit(encR(FN_ADD, 3, 1, 2));
        emit(encI(OP_SW, 3, 0, 16'h0000));
        emit(encR(FN_SUB, 4, 2, 1));
        emit(encI(OP_SW, 4, 0, 16'h0004));
        emit(encR(FN_AND, 5, 1, 2));
        emit(encI(OP_SW, 5, 0, 16'h0008));
        emit(encR(FN_OR, 6, 1, 2));
        emit(encI(OP_SW, 6, 0, 16'h000c));
        emit(encR(FN_SLT, 7, 2, 1));
        emit(encI(OP_SW, 7, 0, 16'h0010));
        emit(encI(OP_SLTI, 8, 1, 16'hffff));
        emit(encI(OP_SW, 8, 0, 16'h0014));
        emit(encI(OP_ANDI, 9, 2, 16'hff0f));
        emit(encI(OP_SW, 9, 0, 16'h0018));
        emit(encI(OP_ORI, 10, 1, 16'h8000));
        emit(encI(OP_SW, 10, 0, 16'h001c));
        emit(encI(OP_LUI, 11, 0, 16'hbeef));
        emit(encI(OP_SW, 11, 0, 16'h0020));
        emit(encI(OP_ADDI, 0, 0, 16'h004d));
        emit(encI(OP_SW, 0, 0, 16'h0024));
        emitJumpSelf();
        runProgram("arith", progLen + 6);

        // Loads and stores on all byte lanes
        clearProgram();
        emit(encI(OP_ADDI, 1, 0, 16'h0040));
        emit(encI(OP_LUI, 2, 0, 16'h8123));
        emit(encI(OP_ORI, 2, 2, 16'h45f6));
        emit(encI(OP_SW, 2, 1, 16'h0000));
        emit(encI(OP_LW, 3, 1, 16'h0000));
        emit(encI(OP_SW, 3, 1, 16'h0004));
        emit(encI(OP_ADDI, 4, 0, 16'h00a5));
        for (int l = 0; l < 4; l++) begin
            emit(encI(OP_SB, 4, 1, 16'(16 + l)));
            emit(encI(OP_ADDI, 4, 4, 16'h0013));
        end
        emit(encI(OP_LW, 9, 1, 16'h0010));
        emit(encI(OP_SW, 9, 1, 16'h0014));
        for (int l = 0; l < 4; l++) begin
            emit(encI(OP_LB, 5 + l, 1, 16'(l)));
            emit(encI(OP_SW, 5 + l, 1, 16'(32 + 4 * l)));
        end
        emit(encI(OP_LB, 10, 1, 16'h0103));
        emit(encI(OP_SW, 10, 1, 16'h0030));
        emitJumpSelf();
        runProgram("loadstore", progLen + 6);

        // Branches forward and backward, and a jump over a store
        clearProgram();
        emit(encI(OP_ADDI, 1, 0, 16'h0001));
        emit(encI(OP_ADDI, 2, 0, 16'h0001));
        emit(encI(OP_BEQ, 2, 1, 16'h0002));
        emit(encI(OP_SW, 1, 0, 16'h0000));
        emit(encI(OP_SW, 1, 0, 16'h0004));
        emit(encI(OP_BNE, 2, 1, 16'h0001));
        emit(encI(OP_SW, 1, 0, 16'h0008));
        emit(encI(OP_ADDI, 3, 0, 16'h0003));
        emit(encI(OP_ADDI, 3, 3, 16'hffff));
        emit(encI(OP_SW, 3, 0, 16'h000c));
        emit(encI(OP_BNE, 0, 3, 16'hfffd));
        emit(encI(OP_BEQ, 1, 3, 16'h0001));
        emit(encJ(26'(RESET_PC[27:2] + 14)));
        emit(encI(OP_SW, 1, 0, 16'h0010));
        emit(encI(OP_SW, 2, 0, 16'h0014));
        emitJumpSelf();
        runProgram("branch", progLen + 12);

        // Two random programs of 100 instructions each
        buildRandom();
        runProgram("random0", progLen + 4);
        buildRandom();
        runProgram("random1", progLen + 4);

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 testCount, passCount, testCount - passCount, errCount);
        if (errCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* cpuTop.sv */
module cpuTop
    import mipsPkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
    input  logic        i_clk,
    input  logic        i_rstN,
    input  logic [31:0] i_imemData,
    input  logic [31:0] i_dmemRdData,
    output logic [31:0] o_imemAddr,
    output dmemReqT     o_dmemReq
);

    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [25:0] jumpIndex;
    logic [31:0] pcPlus4;
    logic        valid;
    ctrlT        ctrl;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic [4:0]  destReg;
    logic        takeBranch;
    logic [31:0] branchTarget;
    regWriteT    regWr;

    // Instruction fields
    assign rsAddr    = i_imemData[25:21];
    assign rtAddr    = i_imemData[20:16];
    assign jumpIndex = i_imemData[25:0];

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////
    fetchUnit #(
        .RESET_PC       (RESET_PC    )
    ) u_fetchUnit (
        .i_clk          (i_clk       ),
        .i_rstN         (i_rstN      ),
        .i_ctrl         (ctrl        ),
        .i_takeBranch   (takeBranch  ),
        .i_branchTarget (branchTarget),
        .i_jumpIndex    (jumpIndex   ),
        .o_pc           (o_imemAddr  ),
        .o_pcPlus4      (pcPlus4     ),
        .o_valid        (valid       )
    );

    ////////////////////////////////////////
    // Decode and register read
    ////////////////////////////////////////
    instrDecoder u_instrDecoder (
        .i_instr        (i_imemData  ),
        .i_valid        (valid       ),
        .o_ctrl         (ctrl        )
    );

    regFile u_regFile (
        .i_clk          (i_clk       ),
        .i_rstN         (i_rstN      ),
        .i_rsAddr       (rsAddr      ),
        .i_rtAddr       (rtAddr      ),
        .i_wr           (regWr       ),
        .o_rsData       (rsData      ),
        .o_rtData       (rtData      )
    );

    ////////////////////////////////////////
    // Execute, memory and writeback
    ////////////////////////////////////////
    executeUnit u_executeUnit (
        .i_instr        (i_imemData  ),
        .i_ctrl         (ctrl        ),
        .i_rsData       (rsData      ),
        .i_rtData       (rtData      ),
        .i_pcPlus4      (pcPlus4     ),
        .o_aluResult    (aluResult   ),
        .o_storeData    (storeData   ),
        .o_destReg      (destReg     ),
        .o_takeBranch   (takeBranch  ),
        .o_branchTarget (branchTarget)
    );

    memAccess u_memAccess (
        .i_ctrl         (ctrl        ),
        .i_aluResult    (aluResult   ),
        .i_storeData    (storeData   ),
        .i_destReg      (destReg     ),
        .i_dmemRdData   (i_dmemRdData),
        .o_dmemReq      (o_dmemReq   ),
        .o_regWr        (regWr       )
    );

endmodule

/* memAccess.sv */
module memAccess
    import mipsPkg::*;
(
    input  ctrlT        i_ctrl,
    input  logic [31:0] i_aluResult,
    input  logic [31:0] i_storeData,
    input  logic [4:0]  i_destReg,
    input  logic [31:0] i_dmemRdData,
    output dmemReqT     o_dmemReq,
    output regWriteT    o_regWr
);

    logic [1:0]  byteSel;
    logic [3:0]  laneMask;
    logic [7:0]  loadByte;
    logic [31:0] loadValue;

    assign byteSel = i_aluResult[1:0];

    // Lane 0 is the least significant byte
    assign laneMask = i_ctrl.byteAccess ? (4'b0001 << byteSel) : 4'b1111;

    ////////////////////////////////////////
    // Data bus request
    ////////////////////////////////////////
    always_comb begin
        o_dmemReq.addr   = {i_aluResult[31:2], 2'b00};
        o_dmemReq.wrData = i_ctrl.byteAccess ? {4{i_storeData[7:0]}} : i_storeData;
        o_dmemReq.byteEn = (i_ctrl.memRead || i_ctrl.memWrite) ? laneMask : 4'b0000;
        o_dmemReq.wrEn   = i_ctrl.memWrite;
    end

    ////////////////////////////////////////
    // Load alignment and writeback
    ////////////////////////////////////////
    always_comb begin
        case (byteSel)
            2'd0:    loadByte = i_dmemRdData[7:0];
            2'd1:    loadByte = i_dmemRdData[15:8];
            2'd2:    loadByte = i_dmemRdData[23:16];
            default: loadByte = i_dmemRdData[31:24];
        endcase
    end

    // lb sign-extends, lw takes the word as is
    assign loadValue = i_ctrl.byteAccess ? {{24{loadByte[7]}}, loadByte} : i_dmemRdData;

    always_comb begin
        o_regWr.en   = i_ctrl.regWrite;
        o_regWr.addr = i_destReg;
        o_regWr.data = i_ctrl.memToReg ? loadValue : i_aluResult;
    end

endmodule

/* executeUnit.sv */
module executeUnit
    import mipsPkg::*;
(
    input  logic [31:0] i_instr,
    input  ctrlT        i_ctrl,
    input  logic [31:0] i_rsData,
    input  logic [31:0] i_rtData,
    input  logic [31:0] i_pcPlus4,
    output logic [31:0] o_aluResult,
    output logic [31:0] o_storeData,
    output logic [4:0]  o_destReg,
    output logic        o_takeBranch,
    output logic [31:0] o_branchTarget
);

    logic [15:0] imm;
    logic [4:0]  rtField;
    logic [4:0]  rdField;
    logic [31:0] immSext;
    logic [31:0] immExt;
    logic [31:0] opB;
    logic [31:0] aluResult;
    logic        zero;

    assign imm     = i_instr[15:0];
    assign rtField = i_instr[20:16];
    assign rdField = i_instr[15:11];

    ////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////
    assign immSext = {{16{imm[15]}}, imm};
    assign immExt  = i_ctrl.zeroExt ? {16'h0000, imm} : immSext;
    assign opB     = i_ctrl.aluSrc ? immExt : i_rtData;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        case (i_ctrl.aluOp)
            ALU_ADD: aluResult = i_rsData + opB;
            ALU_SUB: aluResult = i_rsData - opB;
            ALU_AND: aluResult = i_rsData & opB;
            ALU_OR:  aluResult = i_rsData | opB;
            ALU_SLT: aluResult = {31'd0, $signed(i_rsData) < $signed(opB)};
            ALU_LUI: aluResult = {imm, 16'h0000};
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == 32'd0);

    // Branch compare is the subtraction rs - rt
    assign o_takeBranch   = i_ctrl.branch && (i_ctrl.branchNe ? !zero : zero);
    assign o_branchTarget = i_pcPlus4 + {immSext[29:0], 2'b00};

    assign o_aluResult = aluResult;
    assign o_storeData = i_rtData;
    assign o_destReg   = i_ctrl.regDst ? rdField : rtField;

endmodule

/* regFile.sv */
module regFile
    import mipsPkg::*;
(
    input  logic        i_clk,
    input  logic        i_rstN,
    input  logic [4:0]  i_rsAddr,
    input  logic [4:0]  i_rtAddr,
    input  regWriteT    i_wr,
    output logic [31:0] o_rsData,
    output logic [31:0] o_rtData
);

    logic [31:0] regs [32];

    // Writes land at the end of the cycle, so a same-cycle read
    // of the target still sees the previous value
    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.en && (i_wr.addr != 5'd0)) begin
            regs[i_wr.addr] <= i_wr.data;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////
    // $zero is hardwired
    always_comb begin
        o_rsData = regs[i_rsAddr];
        o_rtData = regs[i_rtAddr];
        if (i_rsAddr == 5'd0) begin
            o_rsData = '0;
        end
        if (i_rtAddr == 5'd0) begin
            o_rtData = '0;
        end
    end

endmodule

/* instrDecoder.sv */
module instrDecoder
    import mipsPkg::*;
(
    input  logic [31:0] i_instr,
    input  logic        i_valid,
    output ctrlT        o_ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    ctrlT       dec;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];

    ////////////////////////////////////////
    // Main and ALU control
    ////////////////////////////////////////
    // Anything not listed falls through as a no-op
    always_comb begin
        dec       = '0;
        dec.aluOp = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                dec.regDst   = 1'b1;
                dec.regWrite = 1'b1;
                case (funct)
                    FN_ADD:  dec.aluOp = ALU_ADD;
                    FN_SUB:  dec.aluOp = ALU_SUB;
                    FN_AND:  dec.aluOp = ALU_AND;
                    FN_OR:   dec.aluOp = ALU_OR;
                    FN_SLT:  dec.aluOp = ALU_SLT;
                    default: dec.regWrite = 1'b0;
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                dec.regWrite = 1'b1;
                dec.aluSrc   = 1'b1;
                // Logical immediates are zero extended
                dec.zeroExt  = (opcode == OP_ANDI) || (opcode == OP_ORI);
                case (opcode)
                    OP_SLTI: dec.aluOp = ALU_SLT;
                    OP_ANDI: dec.aluOp = ALU_AND;
                    OP_ORI:  dec.aluOp = ALU_OR;
                    OP_LUI:  dec.aluOp = ALU_LUI;
                    default: dec.aluOp = ALU_ADD;
                endcase
            end
            OP_LW, OP_LB: begin
                dec.regWrite   = 1'b1;
                dec.memToReg   = 1'b1;
                dec.memRead    = 1'b1;
                dec.aluSrc     = 1'b1;
                dec.byteAccess = (opcode == OP_LB);
            end
            OP_SW, OP_SB: begin
                dec.memWrite   = 1'b1;
                dec.aluSrc     = 1'b1;
                dec.byteAccess = (opcode == OP_SB);
            end
            OP_BEQ, OP_BNE: begin
                dec.branch   = 1'b1;
                dec.branchNe = (opcode == OP_BNE);
                dec.aluOp    = ALU_SUB;
            end
            OP_J: begin
                dec.jump = 1'b1;
            end
            default: begin
                dec = '0;
            end
        endcase
    end

    // Nothing may change state before the first fetch is valid
    always_comb begin
        o_ctrl = dec;
        if (!i_valid) begin
            o_ctrl.regWrite = 1'b0;
            o_ctrl.memWrite = 1'b0;
            o_ctrl.memRead  = 1'b0;
            o_ctrl.branch   = 1'b0;
            o_ctrl.jump     = 1'b0;
        end
    end

endmodule

/* fetchUnit.sv */
module fetchUnit
    import mipsPkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
    input  logic        i_clk,
    input  logic        i_rstN,
    input  ctrlT        i_ctrl,
    input  logic        i_takeBranch,
    input  logic [31:0] i_branchTarget,
    input  logic [25:0] i_jumpIndex,
    output logic [31:0] o_pc,
    output logic [31:0] o_pcPlus4,
    output logic        o_valid
);

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic        valid;

    assign pcPlus4    = pc + 32'd4;
    // Jump keeps the 256 MB region of the delay slot address
    assign jumpTarget = {pcPlus4[31:28], i_jumpIndex, 2'b00};

    // Jump wins over branch, branch over sequential
    always_comb begin
        if (i_ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (i_takeBranch) begin
            nextPc = i_branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    ////////////////////////////////////////
    // PC and valid registers
    ////////////////////////////////////////
    // First edge after reset only raises valid, so the instruction
    // at RESET_PC gets a full cycle before the PC moves on
    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            pc    <= RESET_PC;
            valid <= 1'b0;
        end else begin
            valid <= 1'b1;
            if (valid) begin
                pc <= nextPc;
            end
        end
    end

    assign o_pc      = pc;
    assign o_pcPlus4 = pcPlus4;
    assign o_valid   = valid;

endmodule

/* mipsPkg.sv */
package mipsPkg;

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////

    // Major opcodes in instruction bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LW    = 6'h23,
        OP_SB    = 6'h28,
        OP_SW    = 6'h2b
    } opcodeE;

    // R-type function codes in instruction bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } functE;

    // Operations of the execute stage ALU
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } aluOpE;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Decoded control for one instruction
    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  byteAccess;  // lb / sb
        logic  branch;
        logic  branchNe;    // bne when set, beq otherwise
        logic  jump;
        logic  regDst;      // rd when set, rt otherwise
        logic  aluSrc;      // immediate as second operand
        logic  zeroExt;
        aluOpE aluOp;
    } ctrlT;

    // Data bus request with word address and byte lanes
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wrData;
        logic [3:0]  byteEn;
        logic        wrEn;
    } dmemReqT;

    // One register file write
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } regWriteT;

endpackage
